/* verilog/bp_pkg.sv */
package bp_pkg;

    // meaningful widths
    typedef logic [31:0] pc_t;     // instruction address
    typedef logic [4:0]  hist_t;   // global history with the newest outcome in bit 0
    typedef logic [4:0]  idx_t;    // table index
    typedef logic [24:0] tag_t;    // pc bits 31..7
    typedef logic [1:0]  ctr_t;    // 2-bit saturating counter

    localparam int   ENTRIES       = 32;
    localparam int   IDX_LO        = 2;   // lowest pc bit of the index
    localparam int   TAG_LO        = 7;   // lowest pc bit of the tag
    localparam ctr_t CTR_INIT      = 2'd0;
    localparam ctr_t CTR_TAKEN_MIN = 2'd2; // 2 and 3 predict taken

    // 34 bit fetch side lookup request
    typedef struct packed {
        logic valid;
        logic is_ctrl;   // predecoded control instruction
        pc_t  pc;
    } fetch_query_t;

    // 75 bit execute side report of a resolved control instruction
    typedef struct packed {
        logic  valid;
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  taken;
        logic  mispredict;
        pc_t   pc;
        pc_t   target;
        hist_t hist;      // history used when this instruction was fetched
    } resolve_t;

    // 65 bit write port shared by both tables
    typedef struct packed {
        logic valid;
        logic is_jump;   // jal or jalr
        idx_t idx;
        tag_t tag;
        pc_t  target;
        logic taken;
    } table_update_t;

    // 39 bit lookup result back to fetch
    typedef struct packed {
        pc_t   next_pc;
        logic  taken;
        logic  hit;
        hist_t hist;      // carried down the pipe and returned as resolve hist
    } prediction_t;

    // post-reset table sweep
    typedef enum logic {
        CLEARING,
        RUNNING
    } clear_state_t;

endpackage

/* verilog/update_stage.sv */
`timescale 1ns/1ps

module update_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  bp_pkg::resolve_t      resolve,
    output bp_pkg::table_update_t table_update,
    output logic                  clear,
    output bp_pkg::idx_t          clear_idx,
    output logic                  repair_valid,
    output bp_pkg::hist_t         repair_hist,
    output logic                  ready
);

    bp_pkg::clear_state_t state;
    bp_pkg::resolve_t     res_q;     // resolve report, one cycle old
    logic                 res_ctrl;

    // clear sweep of one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= bp_pkg::CLEARING;
            clear_idx <= '0;
        end else if (state == bp_pkg::CLEARING) begin
            clear_idx <= clear_idx + bp_pkg::idx_t'(1);
            if (clear_idx == bp_pkg::idx_t'(bp_pkg::ENTRIES - 1)) begin
                state <= bp_pkg::RUNNING;   // last entry written at this edge
            end
        end
    end

    // register the execute report
    always_ff @(posedge clk) begin
        if (reset) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q <= resolve;
        end
    end

    assign clear    = (state == bp_pkg::CLEARING);
    assign ready    = (state == bp_pkg::RUNNING);
    assign res_ctrl = res_q.is_branch | res_q.is_jal | res_q.is_jalr;

    // table write from the registered report
    always_comb begin
        table_update.valid   = res_q.valid && res_ctrl && ready;
        table_update.is_jump = res_q.is_jal | res_q.is_jalr;
        table_update.idx     = res_q.pc[bp_pkg::IDX_LO +: $bits(bp_pkg::idx_t)] ^ res_q.hist;
        table_update.tag     = res_q.pc[31:bp_pkg::TAG_LO];
        table_update.target  = res_q.target;
        table_update.taken   = res_q.taken;
    end

    // history as it should have been after this instruction
    assign repair_valid = res_q.valid && res_q.mispredict && ready;
    assign repair_hist  = {res_q.hist[$bits(bp_pkg::hist_t)-2:0], res_q.taken};

    // ready stays up until the next reset
    ready_stays_high: assert property (
        @(posedge clk) disable iff (reset)
        ready |=> ready
    ) else $error("ready fell without reset");

    // execute must hold off until the sweep is done
    no_resolve_while_clearing: assert property (
        @(posedge clk) disable iff (reset)
        (state == bp_pkg::CLEARING) |-> !resolve.valid
    ) else $error("resolve valid during clear sweep");

endmodule

/* verilog/global_history.sv */
`timescale 1ns/1ps

module global_history (
    input  logic                 clk,
    input  logic                 reset,
    input  bp_pkg::fetch_query_t query,
    input  logic                 pred_taken,
    input  logic                 repair_valid,
    input  bp_pkg::hist_t        repair_hist,
    output bp_pkg::hist_t        ghr
);

    logic spec_shift;

    // predicted control fetch shifts in its predicted direction
    assign spec_shift = query.valid && query.is_ctrl;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (repair_valid) begin
            // mispredict repair overrides any speculative shift this cycle
            ghr <= repair_hist;
        end else if (spec_shift) begin
            ghr <= {ghr[$bits(bp_pkg::hist_t)-2:0], pred_taken};
        end
    end

endmodule

/* verilog/pattern_table.sv */
`timescale 1ns/1ps

module pattern_table (
    input  logic                  clk,
    input  logic                  reset,
    input  bp_pkg::idx_t          rd_idx,
    output bp_pkg::ctr_t          rd_ctr,
    input  bp_pkg::table_update_t table_update,
    input  logic                  clear,
    input  bp_pkg::idx_t          clear_idx
);

    bp_pkg::ctr_t ctr_q [bp_pkg::ENTRIES];
    bp_pkg::ctr_t ctr_old;
    bp_pkg::ctr_t ctr_new;

    assign rd_ctr  = ctr_q[rd_idx];
    assign ctr_old = ctr_q[table_update.idx];

    // saturating step for branches
    always_comb begin
        if (table_update.is_jump) begin
            ctr_new = '1;                       // jumps go straight to strongly taken
        end else if (table_update.taken) begin
            ctr_new = (ctr_old == '1) ? ctr_old : ctr_old + 1'b1;
        end else begin
            ctr_new = (ctr_old == '0) ? ctr_old : ctr_old - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            ctr_q[clear_idx] <= bp_pkg::CTR_INIT;
        end else if (table_update.valid) begin
            ctr_q[table_update.idx] <= ctr_new;
        end
    end

    // update_stage blocks writes while the sweep runs
    no_update_during_clear: assert property (
        @(posedge clk) disable iff (reset)
        !(clear && table_update.valid)
    ) else $error("pattern table update during clear");

endmodule

/* verilog/target_buffer.sv */
`timescale 1ns/1ps

module target_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  bp_pkg::idx_t          rd_idx,
    input  bp_pkg::tag_t          rd_tag,
    output logic                  hit,
    output bp_pkg::pc_t           rd_target,
    input  bp_pkg::table_update_t table_update,
    input  logic                  clear,
    input  bp_pkg::idx_t          clear_idx
);

    bp_pkg::tag_t               tag_q    [bp_pkg::ENTRIES];
    bp_pkg::pc_t                target_q [bp_pkg::ENTRIES];
    logic [bp_pkg::ENTRIES-1:0] valid_q;
    logic                       wr_en;

    // not-taken reports leave the entry alone
    assign wr_en = table_update.valid && table_update.taken;

    assign hit       = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rd_target = target_q[rd_idx];

    always_ff @(posedge clk) begin
        if (clear) begin
            valid_q[clear_idx] <= 1'b0;
        end else if (wr_en) begin
            valid_q[table_update.idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[table_update.idx]    <= table_update.tag;
            target_q[table_update.idx] <= table_update.target;
        end
    end

    // a taken write during the sweep would lose its valid bit to the clear
    no_write_during_clear: assert property (
        @(posedge clk) disable iff (reset)
        !(clear && wr_en)
    ) else $error("target buffer write during clear");

endmodule

/* verilog/next_pc_select.sv */
`timescale 1ns/1ps

module next_pc_select (
    input  bp_pkg::fetch_query_t query,
    input  bp_pkg::hist_t        ghr,
    output bp_pkg::idx_t         rd_idx,
    output bp_pkg::tag_t         rd_tag,
    input  bp_pkg::ctr_t         rd_ctr,
    input  logic                 hit,
    input  bp_pkg::pc_t          rd_target,
    output bp_pkg::prediction_t  prediction
);

    logic ctr_taken;
    logic pred_taken;

    // gshare index and btb tag from the fetch pc
    assign rd_idx = query.pc[bp_pkg::IDX_LO +: $bits(bp_pkg::idx_t)] ^ ghr;
    assign rd_tag = query.pc[31:bp_pkg::TAG_LO];

    assign ctr_taken  = (rd_ctr >= bp_pkg::CTR_TAKEN_MIN);
    assign pred_taken = query.valid && query.is_ctrl && hit && ctr_taken;

    always_comb begin
        prediction.taken   = pred_taken;
        prediction.hit     = hit;
        prediction.hist    = ghr;       // history this lookup used
        prediction.next_pc = pred_taken ? rd_target : query.pc + 32'd4;
    end

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
    input  logic                 clk,
    input  logic                 reset,
    input  bp_pkg::fetch_query_t query,
    input  bp_pkg::resolve_t     resolve,
    output bp_pkg::prediction_t  prediction,
    output logic                 ready
);

    bp_pkg::table_update_t table_update;
    logic                  clear;
    bp_pkg::idx_t          clear_idx;
    logic                  repair_valid;
    bp_pkg::hist_t         repair_hist;
    bp_pkg::hist_t         ghr;
    bp_pkg::idx_t          rd_idx;
    bp_pkg::tag_t          rd_tag;
    bp_pkg::ctr_t          rd_ctr;
    logic                  hit;
    bp_pkg::pc_t           rd_target;

    // execute reports, table writes and clear sweep
    update_stage u_update (
        .clk          (clk),
        .reset        (reset),
        .resolve      (resolve),
        .table_update (table_update),
        .clear        (clear),
        .clear_idx    (clear_idx),
        .repair_valid (repair_valid),
        .repair_hist  (repair_hist),
        .ready        (ready)
    );

    global_history u_history (
        .clk          (clk),
        .reset        (reset),
        .query        (query),
        .pred_taken   (prediction.taken),
        .repair_valid (repair_valid),
        .repair_hist  (repair_hist),
        .ghr          (ghr)
    );

    pattern_table u_pht (
        .clk          (clk),
        .reset        (reset),
        .rd_idx       (rd_idx),
        .rd_ctr       (rd_ctr),
        .table_update (table_update),
        .clear        (clear),
        .clear_idx    (clear_idx)
    );

    target_buffer u_btb (
        .clk          (clk),
        .reset        (reset),
        .rd_idx       (rd_idx),
        .rd_tag       (rd_tag),
        .hit          (hit),
        .rd_target    (rd_target),
        .table_update (table_update),
        .clear        (clear),
        .clear_idx    (clear_idx)
    );

    // same-cycle lookup for fetch
    next_pc_select u_select (
        .query      (query),
        .ghr        (ghr),
        .rd_idx     (rd_idx),
        .rd_tag     (rd_tag),
        .rd_ctr     (rd_ctr),
        .hit        (hit),
        .rd_target  (rd_target),
        .prediction (prediction)
    );

endmodule

/* verif/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// shadow copy of both tables and the history
bp_pkg::ctr_t     sh_ctr    [bp_pkg::ENTRIES];
bp_pkg::tag_t     sh_tag    [bp_pkg::ENTRIES];
bp_pkg::pc_t      sh_target [bp_pkg::ENTRIES];
logic             sh_valid  [bp_pkg::ENTRIES];
bp_pkg::hist_t    sh_hist;
bp_pkg::resolve_t sh_pending;   // report taken in at the last edge that lands at the next

function automatic void model_clear();
    for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
        sh_ctr[i]    = 2'd0;
        sh_tag[i]    = '0;
        sh_target[i] = '0;
        sh_valid[i]  = 1'b0;
    end
    sh_hist    = '0;
    sh_pending = '0;
endfunction

// pc bits 6..2 xor history
function automatic bp_pkg::idx_t model_index(input bp_pkg::pc_t pc, input bp_pkg::hist_t hist);
    return pc[6:2] ^ hist;
endfunction

function automatic bp_pkg::prediction_t expected_prediction(input bp_pkg::fetch_query_t q);
    bp_pkg::prediction_t p;
    bp_pkg::idx_t        idx;
    idx       = model_index(q.pc, sh_hist);
    p.hit     = sh_valid[idx] && (sh_tag[idx] == q.pc[31:7]);
    p.taken   = q.valid && q.is_ctrl && p.hit && (sh_ctr[idx] >= 2'd2);
    p.next_pc = p.taken ? sh_target[idx] : q.pc + 32'd4;
    p.hist    = sh_hist;
    return p;
endfunction

// advance the shadow state across one clock edge
function automatic void model_step(input bp_pkg::fetch_query_t q, input bp_pkg::resolve_t r,
                                   input logic pred_taken);
    bp_pkg::idx_t idx;
    logic         is_ctrl;
    idx     = model_index(sh_pending.pc, sh_pending.hist);
    is_ctrl = sh_pending.is_branch || sh_pending.is_jal || sh_pending.is_jalr;
    if (sh_pending.valid && is_ctrl) begin
        if (sh_pending.is_jal || sh_pending.is_jalr) begin
            sh_ctr[idx] = 2'd3;
        end else if (sh_pending.taken && sh_ctr[idx] != 2'd3) begin
            sh_ctr[idx] = sh_ctr[idx] + 2'd1;
        end else if (!sh_pending.taken && sh_ctr[idx] != 2'd0) begin
            sh_ctr[idx] = sh_ctr[idx] - 2'd1;
        end
        if (sh_pending.taken) begin
            sh_tag[idx]    = sh_pending.pc[31:7];
            sh_target[idx] = sh_pending.target;
            sh_valid[idx]  = 1'b1;
        end
    end
    if (sh_pending.valid && sh_pending.mispredict) begin
        sh_hist = {sh_pending.hist[3:0], sh_pending.taken};   // repair beats shift
    end else if (q.valid && q.is_ctrl) begin
        sh_hist = {sh_hist[3:0], pred_taken};
    end
    sh_pending = r;
endfunction

`endif

/* verif/bp_tb.sv */
`timescale 1ns/1ps

module bp_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 200;   // upper bound for tests 1 to 5
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MARGIN_CYCLES   = 100;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + bp_pkg::ENTRIES + DIRECTED_CYCLES
                                      + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    // resolve kinds
    localparam logic [1:0] K_NONE   = 2'd0;
    localparam logic [1:0] K_BRANCH = 2'd1;
    localparam logic [1:0] K_JAL    = 2'd2;
    localparam logic [1:0] K_JALR   = 2'd3;

    localparam bp_pkg::pc_t   BR_PC        = 32'h0000_1040;   // index 16
    localparam bp_pkg::pc_t   BR_TGT       = 32'h0000_1800;
    localparam bp_pkg::pc_t   ALIAS_PC     = 32'h0000_10c0;   // index 16 with another tag
    localparam bp_pkg::pc_t   JAL_PC       = 32'h0000_2008;   // index 2
    localparam bp_pkg::pc_t   JAL_TGT      = 32'h0000_2400;
    localparam bp_pkg::pc_t   SPARE_PC     = 32'h0000_3014;   // index 5
    localparam bp_pkg::hist_t CARRIED_HIST = 5'b00001;

    localparam bp_pkg::fetch_query_t NO_QUERY   = '0;
    localparam bp_pkg::resolve_t     NO_RESOLVE = '0;

    logic                 clk = 1'b0;
    logic                 reset;
    bp_pkg::fetch_query_t query;
    bp_pkg::resolve_t     resolve;
    bp_pkg::prediction_t  prediction;
    logic                 ready;
    bp_pkg::prediction_t  expected;
    int                   errors = 0;

    `include "bp_ref_model.svh"

    branch_predictor DUT (
        .clk        (clk),
        .reset      (reset),
        .query      (query),
        .resolve    (resolve),
        .prediction (prediction),
        .ready      (ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR: %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic bp_pkg::fetch_query_t make_query(input logic valid, input logic is_ctrl,
                                                        input bp_pkg::pc_t pc);
        bp_pkg::fetch_query_t q;
        q.valid   = valid;
        q.is_ctrl = is_ctrl;
        q.pc      = pc;
        return q;
    endfunction

    function automatic bp_pkg::resolve_t make_resolve(input logic [1:0] kind, input logic taken,
                                                      input logic mispredict, input bp_pkg::pc_t pc,
                                                      input bp_pkg::pc_t target,
                                                      input bp_pkg::hist_t hist);
        bp_pkg::resolve_t r;
        r.valid      = (kind != K_NONE);
        r.is_branch  = (kind == K_BRANCH);
        r.is_jal     = (kind == K_JAL);
        r.is_jalr    = (kind == K_JALR);
        r.taken      = taken;
        r.mispredict = mispredict;
        r.pc         = pc;
        r.target     = target;
        r.hist       = hist;
        return r;
    endfunction

    // 4 tags x 8 low indices so entries alias
    function automatic bp_pkg::pc_t pool_pc();
        return 32'h0000_1000 | (($urandom % 4) << 7) | (($urandom % 8) << 2);
    endfunction

    function automatic bp_pkg::pc_t pool_target();
        return 32'h0000_8000 | (($urandom % 256) << 2);
    endfunction

    task automatic step(input bp_pkg::fetch_query_t q, input bp_pkg::resolve_t r);
        @(posedge clk);
        query   <= q;
        resolve <= r;
    endtask

    task automatic idle(input int n);
        repeat (n) step(NO_QUERY, NO_RESOLVE);
    endtask

    task automatic send_resolve(input logic [1:0] kind, input logic taken, input logic mispredict,
                                input bp_pkg::pc_t pc, input bp_pkg::pc_t target,
                                input bp_pkg::hist_t hist);
        step(NO_QUERY, make_resolve(kind, taken, mispredict, pc, target, hist));
    endtask

    task automatic train_branch(input logic taken);
        send_resolve(K_BRANCH, taken, 1'b0, BR_PC, BR_TGT, 5'b0);
    endtask

    // mispredicted not-taken branch with empty history brings ghr back to zero
    task automatic zero_history();
        send_resolve(K_BRANCH, 1'b0, 1'b1, SPARE_PC, SPARE_PC, 5'b0);
        idle(2);
    endtask

    task automatic probe(input bp_pkg::pc_t pc, input logic exp_hit, input logic exp_taken,
                         input bp_pkg::pc_t exp_next, input string what);
        idle(2);   // let earlier resolves reach the tables
        step(make_query(1'b1, 1'b1, pc), NO_RESOLVE);
        @(negedge clk);
        check_value(32'(prediction.hit), 32'(exp_hit), {what, " hit"});
        check_value(32'(prediction.taken), 32'(exp_taken), {what, " taken"});
        check_value(prediction.next_pc, exp_next, {what, " next_pc"});
    endtask

    // compare against the shadow model mid-cycle and then step it
    always @(negedge clk) begin
        if (reset) begin
            model_clear();
        end else if (ready) begin
            expected = expected_prediction(query);
            check_value(prediction.next_pc, expected.next_pc, "next_pc");
            check_value(32'(prediction.taken), 32'(expected.taken), "taken");
            check_value(32'(prediction.hit), 32'(expected.hit), "hit");
            check_value(32'(prediction.hist), 32'(expected.hist), "hist");
            model_step(query, resolve, expected.taken);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: %0t: watchdog expired, the test did not finish in time", $time);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        int            ready_wait;
        logic [1:0]    kind;
        logic          taken;
        bp_pkg::pc_t   pc;

        $timeformat(-9, 0, " ns", 0);
        reset     = 1'b1;
        query     = NO_QUERY;
        resolve   = NO_RESOLVE;
        void'($urandom(73));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // test 1 counts the sweep cycles and then queries an empty predictor
        ready_wait = 0;
        @(negedge clk);
        while (!ready) begin
            ready_wait++;   // one cycle with ready low
            @(negedge clk);
        end
        check_value(ready_wait, bp_pkg::ENTRIES, "cycles until ready");
        for (int i = 0; i < 16; i++) begin
            pc = pool_pc();
            step(make_query(1'b1, 1'($urandom % 2), pc), NO_RESOLVE);
            @(negedge clk);
            check_value(32'(prediction.hit), 32'd0, "empty table hit");
            check_value(prediction.next_pc, pc + 32'd4, "empty table next_pc");
        end

        // test 3 trains the counter with saturation while ghr stays at zero
        train_branch(1'b1);
        probe(BR_PC, 1'b1, 1'b0, BR_PC + 32'd4, "counter 1");
        train_branch(1'b1);
        probe(BR_PC, 1'b1, 1'b1, BR_TGT, "counter 2");
        zero_history();
        train_branch(1'b1);
        train_branch(1'b1);
        probe(BR_PC, 1'b1, 1'b1, BR_TGT, "counter 3 saturated");
        zero_history();
        train_branch(1'b0);
        probe(BR_PC, 1'b1, 1'b1, BR_TGT, "counter back to 2");
        zero_history();
        train_branch(1'b0);
        probe(BR_PC, 1'b1, 1'b0, BR_PC + 32'd4, "counter back to 1");
        train_branch(1'b0);
        train_branch(1'b0);
        train_branch(1'b0);
        train_branch(1'b1);
        probe(BR_PC, 1'b1, 1'b0, BR_PC + 32'd4, "counter 0 saturated");

        // test 4 same index with another tag
        probe(ALIAS_PC, 1'b0, 1'b0, ALIAS_PC + 32'd4, "aliased tag");

        // test 2 jal fills the target buffer
        send_resolve(K_JAL, 1'b1, 1'b0, JAL_PC, JAL_TGT, 5'b0);
        probe(JAL_PC, 1'b1, 1'b1, JAL_TGT, "jal target");

        // test 5 ghr is now 00001 so the same pc lands on an empty entry
        probe(JAL_PC, 1'b0, 1'b0, JAL_PC + 32'd4, "shifted index");
        send_resolve(K_JAL, 1'b1, 1'b1, JAL_PC, JAL_TGT, CARRIED_HIST);
        idle(2);
        step(make_query(1'b1, 1'b0, JAL_PC), NO_RESOLVE);
        @(negedge clk);
        check_value(32'(prediction.hist), 32'({CARRIED_HIST[3:0], 1'b1}), "repaired history");

        // test 6 random mix
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            kind  = 2'($urandom % 4);
            taken = (kind == K_JAL || kind == K_JALR) ? 1'b1 : 1'($urandom % 2);
            step(make_query(($urandom % 4) != 0, 1'($urandom % 2), pool_pc()),
                 make_resolve(kind, taken, ($urandom % 4) == 0, pool_pc(), pool_target(),
                              bp_pkg::hist_t'($urandom)));
        end
        idle(3);   // drain the last resolve

        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verif
verilog/bp_pkg.sv
verilog/update_stage.sv
verilog/global_history.sv
verilog/pattern_table.sv
verilog/target_buffer.sv
verilog/next_pc_select.sv
verilog/branch_predictor.sv
verif/bp_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bp_tb -f vlog.f -o bp_sim \
    > build.log 2>&1 && ./obj_dir/bp_sim > sim.log 2>&1 || echo "build or simulation error"
[ -f sim.log ] && cat sim.log
grep -q "^Testbench passed$" sim.log 2>/dev/null && echo "PASS" && exit 0 || {
    echo "FAIL"
    exit 1
}
